// File: aluDecoder.sv
// ALU decoder
// Picks the ALU operation from the instruction class and the function
// field. Memory accesses and the jump use a plain add for the address.

`timescale 1ns/10ps

module aluDecoder (
    input  ctrlPkg::opcodeT  opcode,
    input  ctrlPkg::funcT    func,
    input  logic             aluOp,
    output ctrlPkg::aluCtrlT aluCtrl
);
    import ctrlPkg::*;

    always_comb begin
        aluCtrl = aluAdd;                // address computation
        if (aluOp) begin
            casez (opcode)
                opAluReg, opAluVec: begin
                    case (func)
                        3'b000:  aluCtrl = aluAdd;
                        3'b001:  aluCtrl = aluSub;
                        3'b010:  aluCtrl = aluAnd;
                        3'b100:  aluCtrl = aluOr;
                        3'b101:  aluCtrl = aluXor;
                        3'b011:  aluCtrl = aluSll;
                        3'b111:  aluCtrl = aluSrl;
                        default: aluCtrl = aluAdd;   // 110 is unused
                    endcase
                end
                opAluImm: begin
                    case (opcode[1:0])
                        2'b00:   aluCtrl = aluAdd;
                        2'b01:   aluCtrl = aluSub;
                        2'b10:   aluCtrl = aluAnd;
                        default: aluCtrl = aluOr;
                    endcase
                end
                opBrCond: aluCtrl = aluSub;      // compare sets the flags
                default:  aluCtrl = aluAdd;
            endcase
        end
    end

endmodule

// File: branchResolve.sv
// Branch resolver
// Decides in the execute stage whether the branch held there is taken,
// from its condition and the zero and negative flags of the compare.

`timescale 1ns/10ps

module branchResolve (
    input  ctrlPkg::condT cond,
    input  logic          zero,
    input  logic          negative,
    output logic          pcSrc
);
    import ctrlPkg::*;

    always_comb begin
        case (cond)
            condAlways: pcSrc = 1'b1;
            condEq:     pcSrc = zero;
            condGt:     pcSrc = !zero && !negative;   // strictly greater
            default:    pcSrc = 1'b0;
        endcase
    end

    // only a branch may redirect the fetch
    noBranchNoTake: assert final (!(pcSrc && cond == condNone))
        else $error("pcSrc high without a branch in execute");

endmodule

// File: controlUnit.sv
// Pipelined control unit
// Decodes the instruction in decode, stages its control through the
// execute and memory stage registers and resolves branches in execute.
// A taken branch or a flush turns the execute entry into a bubble, a
// stall in execute sends a bubble on to memory.

`timescale 1ns/10ps

module controlUnit (
    input  logic             clk,
    input  logic             arstN,
    input  ctrlPkg::opcodeT  opcode,
    input  ctrlPkg::funcT    func,
    input  logic             zero,
    input  logic             negative,
    input  logic             stallE,
    input  logic             stallM,
    input  logic             flushE,
    output logic             illegalOp,
    output ctrlPkg::immSrcT  immSrc,
    output ctrlPkg::regSrcT  regSrc,
    output ctrlPkg::aluCtrlT aluCtrlE,
    output logic             aluSrcE,
    output logic             pcSrc,
    output logic             regWM,
    output logic             regWVM,
    output logic             memtoRegM,
    output logic             memWM,
    output logic             memSrcM,
    output logic             memDataM,
    output logic             memDataVM,
    output logic             vecDataM
);
    import ctrlPkg::*;

    logic    regWD, regWVD, memtoRegD, memWD, memSrcD;
    logic    memDataD, memDataVD, vecDataD;
    logic    aluOpD, aluSrcD;
    condT    condD;
    aluCtrlT aluCtrlD;
    exCtrlT  exD, exE;
    memCtrlT memM;
    logic    holdE, clearE, holdM, clearM;

    mainDecoder mainDec (
        .opcode   (opcode),
        .func     (func),
        .regW     (regWD),
        .regWV    (regWVD),
        .memtoReg (memtoRegD),
        .memW     (memWD),
        .memSrc   (memSrcD),
        .memData  (memDataD),
        .memDataV (memDataVD),
        .vecData  (vecDataD),
        .aluOp    (aluOpD),
        .aluSrc   (aluSrcD),
        .illegalOp(illegalOp),
        .cond     (condD),
        .regSrc   (regSrc),
        .immSrc   (immSrc)
    );

    aluDecoder aluDec (
        .opcode (opcode),
        .func   (func),
        .aluOp  (aluOpD),
        .aluCtrl(aluCtrlD)
    );

    assign exD = '{
        aluCtrl: aluCtrlD,
        aluSrc:  aluSrcD,
        cond:    condD,
        mem:     '{regWD, regWVD, memtoRegD, memWD, memSrcD,
                   memDataD, memDataVD, vecDataD}
    };

    // a stall further down also freezes execute
    assign holdE  = stallE | stallM;
    assign clearE = (flushE | pcSrc) & ~holdE;    // kill the wrong-path entry
    assign holdM  = stallM;
    assign clearM = stallE & ~stallM;             // bubble behind a stalled execute

    ctrlStageReg #(.payloadT(exCtrlT)) regE (
        .clk  (clk),
        .arstN(arstN),
        .hold (holdE),
        .clear(clearE),
        .d    (exD),
        .q    (exE)
    );

    ctrlStageReg #(.payloadT(memCtrlT)) regM (
        .clk  (clk),
        .arstN(arstN),
        .hold (holdM),
        .clear(clearM),
        .d    (exE.mem),
        .q    (memM)
    );

    branchResolve brRes (
        .cond    (exE.cond),
        .zero    (zero),
        .negative(negative),
        .pcSrc   (pcSrc)
    );

    assign aluCtrlE  = exE.aluCtrl;
    assign aluSrcE   = exE.aluSrc;
    assign regWM     = memM.regW;
    assign regWVM    = memM.regWV;
    assign memtoRegM = memM.memtoReg;
    assign memWM     = memM.memW;
    assign memSrcM   = memM.memSrc;
    assign memDataM  = memM.memData;
    assign memDataVM = memM.memDataV;
    assign vecDataM  = memM.vecData;

endmodule

// File: controlUnitTb.sv
// Control unit testbench
// Applies a table of instructions, flags, stalls and flushes to the control
// unit and checks the decode, execute and memory levels. An expected model
// of the two stage registers follows the hold and clear rules of the pipe.

`timescale 1ns/10ps

module controlUnitTb;
    import ctrlPkg::*;

    logic    clk;
    logic    arstN;
    opcodeT  opcode;
    funcT    func;
    logic    zero, negative;
    logic    stallE, stallM, flushE;
    logic    illegalOp;
    immSrcT  immSrc;
    regSrcT  regSrc;
    aluCtrlT aluCtrlE;
    logic    aluSrcE, pcSrc;
    logic    regWM, regWVM, memtoRegM, memWM, memSrcM;
    logic    memDataM, memDataVM, vecDataM;
    memCtrlT gotM;

    typedef struct packed {
        opcodeT     op;
        funcT       fn;
        logic [4:0] flags;               // zero, negative, stallE, stallM, flushE
        logic       ill;
        immSrcT     imm;
        regSrcT     rs;
        exCtrlT     ex;                  // expected decode payload
    } rowT;

    rowT     rows[$];
    exCtrlT  expE;                       // expected execute register
    memCtrlT expM;                       // expected memory register
    integer  seed;

    assign gotM = {regWM, regWVM, memtoRegM, memWM, memSrcM, memDataM, memDataVM, vecDataM};

    controlUnit i_controlUnit (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        arstN <= 1'b0;
        repeat (2) @(negedge clk);
        arstN <= 1'b1;
    end

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "level mismatch");
        end
    endtask

    task automatic checkAlu(input aluCtrlT got, input aluCtrlT exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "ALU operation mismatch");
        end
    endtask

    task automatic checkMem(input memCtrlT got, input memCtrlT exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "memory levels mismatch");
        end
    endtask

    task automatic checkImm(input immSrcT got, input immSrcT exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "immediate source mismatch");
        end
    endtask

    task automatic checkRegSrc(input regSrcT got, input regSrcT exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "register source mismatch");
        end
    endtask

    function automatic logic branchTaken(input condT c, input logic z, input logic n);
        case (c)
            condAlways: return 1'b1;
            condEq:     return z;
            condGt:     return !z && !n;     // strictly greater than
            default:    return 1'b0;
        endcase
    endfunction

    function automatic logic isLegalOp(input opcodeT op);
        case (op)
            6'b000000, 6'b100000,                          // register arithmetic
            6'b001000, 6'b001001, 6'b001010, 6'b001011,    // immediate arithmetic
            6'b011000, 6'b011001, 6'b111000, 6'b111001,    // loads and stores
            6'b001100, 6'b001101, 6'b000100:               // branches
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    // one clock edge of the expected pipe
    task automatic advanceModel(input rowT r);
        logic taken;
        logic stE;
        logic stM;
        logic flE;
        taken = branchTaken(expE.cond, r.flags[4], r.flags[3]);
        stE   = r.flags[2];
        stM   = r.flags[1];
        flE   = r.flags[0];
        // memory first, it takes the old execute entry
        if (stE && !stM)
            expM = '0;                   // bubble behind the stalled execute
        else if (!stM)
            expM = expE.mem;
        if (!(stE || stM)) begin
            if (flE || taken)
                expE = '0;
            else
                expE = r.ex;
        end
    endtask

    task automatic addRow(input opcodeT op, input funcT fn, input logic [4:0] flags,
                          input logic ill, input immSrcT imm, input regSrcT rs,
                          input exCtrlT ex);
        rowT r;
        r = {op, fn, flags, ill, imm, rs, ex};
        rows.push_back(r);
    endtask

    task automatic buildTable;
        integer rnd;
        // scalar register arithmetic
        addRow(6'b000000, 3'b000, 5'b00000, 1'b0, immI, 2'b00, {aluAdd, 1'b0, condNone, 8'h80});
        addRow(6'b000000, 3'b001, 5'b00000, 1'b0, immI, 2'b00, {aluSub, 1'b0, condNone, 8'h80});
        addRow(6'b000000, 3'b010, 5'b00000, 1'b0, immI, 2'b00, {aluAnd, 1'b0, condNone, 8'h80});
        addRow(6'b000000, 3'b100, 5'b00000, 1'b0, immI, 2'b00, {aluOr, 1'b0, condNone, 8'h80});
        addRow(6'b000000, 3'b101, 5'b00000, 1'b0, immI, 2'b00, {aluXor, 1'b0, condNone, 8'h80});
        addRow(6'b000000, 3'b011, 5'b00000, 1'b0, immShamt, 2'b00, {aluSll, 1'b1, condNone, 8'h80});
        addRow(6'b000000, 3'b111, 5'b00000, 1'b0, immShamt, 2'b00, {aluSrl, 1'b1, condNone, 8'h80});
        addRow(6'b000000, 3'b110, 5'b00000, 1'b0, immI, 2'b00, {aluAdd, 1'b0, condNone, 8'h80});
        // vector arithmetic never takes a shift amount
        addRow(6'b100000, 3'b001, 5'b00000, 1'b0, immI, 2'b00, {aluSub, 1'b0, condNone, 8'h40});
        addRow(6'b100000, 3'b011, 5'b00000, 1'b0, immI, 2'b00, {aluSll, 1'b0, condNone, 8'h40});
        // immediate arithmetic
        addRow(6'b001000, 3'b000, 5'b00000, 1'b0, immI, 2'b00, {aluAdd, 1'b1, condNone, 8'h80});
        addRow(6'b001001, 3'b110, 5'b00000, 1'b0, immI, 2'b00, {aluSub, 1'b1, condNone, 8'h80});
        addRow(6'b001010, 3'b000, 5'b00000, 1'b0, immI, 2'b00, {aluAnd, 1'b1, condNone, 8'h80});
        addRow(6'b001011, 3'b000, 5'b00000, 1'b0, immI, 2'b00, {aluOr, 1'b1, condNone, 8'h80});
        // ldr, str, ldrv, strv
        addRow(6'b011001, 3'b000, 5'b00000, 1'b0, immI, 2'b00, {aluAdd, 1'b1, condNone, 8'hA0});
        addRow(6'b011000, 3'b000, 5'b00000, 1'b0, immI, 2'b01, {aluAdd, 1'b1, condNone, 8'h10});
        addRow(6'b111001, 3'b000, 5'b00000, 1'b0, immI, 2'b00, {aluAdd, 1'b1, condNone, 8'h69});
        addRow(6'b111000, 3'b000, 5'b00000, 1'b0, immI, 2'b01, {aluAdd, 1'b1, condNone, 8'h18});
        // beq taken, the add behind it is killed
        addRow(6'b001100, 3'b000, 5'b00000, 1'b0, immI, 2'b01, {aluSub, 1'b0, condEq, 8'h00});
        addRow(6'b000000, 3'b000, 5'b10000, 1'b0, immI, 2'b00, {aluAdd, 1'b0, condNone, 8'h80});
        // bgt not taken on negative, then taken
        addRow(6'b001101, 3'b000, 5'b00000, 1'b0, immI, 2'b01, {aluSub, 1'b0, condGt, 8'h00});
        addRow(6'b001011, 3'b000, 5'b01000, 1'b0, immI, 2'b00, {aluOr, 1'b1, condNone, 8'h80});
        addRow(6'b001101, 3'b000, 5'b00000, 1'b0, immI, 2'b01, {aluSub, 1'b0, condGt, 8'h00});
        addRow(6'b011001, 3'b000, 5'b00000, 1'b0, immI, 2'b00, {aluAdd, 1'b1, condNone, 8'hA0});
        // beq not taken
        addRow(6'b001100, 3'b000, 5'b00000, 1'b0, immI, 2'b01, {aluSub, 1'b0, condEq, 8'h00});
        addRow(6'b000000, 3'b001, 5'b01000, 1'b0, immI, 2'b00, {aluSub, 1'b0, condNone, 8'h80});
        // b ignores the flags
        addRow(6'b000100, 3'b000, 5'b00000, 1'b0, immB, 2'b00, {aluAdd, 1'b0, condAlways, 8'h00});
        addRow(6'b011001, 3'b000, 5'b11000, 1'b0, immI, 2'b00, {aluAdd, 1'b1, condNone, 8'hA0});
        // taken beq held by stallE first, cleared one cycle later
        addRow(6'b001100, 3'b000, 5'b00000, 1'b0, immI, 2'b01, {aluSub, 1'b0, condEq, 8'h00});
        addRow(6'b001000, 3'b000, 5'b10100, 1'b0, immI, 2'b00, {aluAdd, 1'b1, condNone, 8'h80});
        addRow(6'b001000, 3'b000, 5'b10000, 1'b0, immI, 2'b00, {aluAdd, 1'b1, condNone, 8'h80});
        // stallE, stallM and flushE
        addRow(6'b011001, 3'b000, 5'b00000, 1'b0, immI, 2'b00, {aluAdd, 1'b1, condNone, 8'hA0});
        addRow(6'b011000, 3'b000, 5'b00100, 1'b0, immI, 2'b01, {aluAdd, 1'b1, condNone, 8'h10});
        addRow(6'b011000, 3'b000, 5'b00000, 1'b0, immI, 2'b01, {aluAdd, 1'b1, condNone, 8'h10});
        addRow(6'b111001, 3'b000, 5'b00010, 1'b0, immI, 2'b00, {aluAdd, 1'b1, condNone, 8'h69});
        addRow(6'b111001, 3'b000, 5'b00000, 1'b0, immI, 2'b00, {aluAdd, 1'b1, condNone, 8'h69});
        addRow(6'b000000, 3'b000, 5'b00001, 1'b0, immI, 2'b00, {aluAdd, 1'b0, condNone, 8'h80});
        // unimplemented opcodes
        addRow(6'b011010, 3'b000, 5'b00000, 1'b1, immI, 2'b00, {aluAdd, 1'b0, condNone, 8'h00});
        addRow(6'b000101, 3'b000, 5'b00000, 1'b1, immI, 2'b00, {aluAdd, 1'b0, condNone, 8'h00});
        addRow(6'b111111, 3'b011, 5'b00000, 1'b1, immI, 2'b00, {aluAdd, 1'b0, condNone, 8'h00});
        addRow(6'b000001, 3'b011, 5'b00000, 1'b1, immI, 2'b00, {aluAdd, 1'b0, condNone, 8'h00});
        // random filler, unimplemented opcodes only
        for (int k = 0; k < 12; k++) begin
            rnd = $random(seed);
            while (isLegalOp(rnd[5:0])) begin
                rnd = $random(seed);
            end
            addRow(rnd[5:0], rnd[8:6],
                   {rnd[9], rnd[10], rnd[11] & rnd[12], rnd[13] & rnd[14], rnd[15] & rnd[16]},
                   1'b1, immI, 2'b00, {aluAdd, 1'b0, condNone, 8'h00});
        end
    endtask

    initial begin
        integer timer;
        opcode   = 6'b111111;            // unimplemented, decodes to a bubble
        func     = '0;
        zero     = 1'b0;
        negative = 1'b0;
        stallE   = 1'b0;
        stallM   = 1'b0;
        flushE   = 1'b0;
        expE     = '0;
        expM     = '0;
        seed     = 28939;
        buildTable();

        timer = 0;
        while (arstN !== 1'b1) begin
            if (timer == 10) begin
                $display("reset still asserted after %0d clock cycles", timer);
                $display("test failed");
                $fatal(1, "reset timeout");
            end else begin
                @(negedge clk);
                timer = timer + 1;
            end
        end

        checkMem(gotM, '0, "memory levels after reset");
        checkBit(pcSrc, 1'b0, "pcSrc after reset");
        checkAlu(aluCtrlE, aluAdd, "aluCtrlE after reset");

        for (int i = 0; i < rows.size(); i++) begin
            opcode = rows[i].op;
            func   = rows[i].fn;
            {zero, negative, stallE, stallM, flushE} = rows[i].flags;
            #1;
            checkBit(illegalOp, rows[i].ill, $sformatf("row %0d illegalOp", i));
            checkImm(immSrc, rows[i].imm, $sformatf("row %0d immSrc", i));
            checkRegSrc(regSrc, rows[i].rs, $sformatf("row %0d regSrc", i));
            checkBit(pcSrc, branchTaken(expE.cond, zero, negative),
                     $sformatf("row %0d pcSrc", i));
            @(posedge clk);
            advanceModel(rows[i]);
            @(negedge clk);
            checkAlu(aluCtrlE, expE.aluCtrl, $sformatf("row %0d aluCtrlE", i));
            checkBit(aluSrcE, expE.aluSrc, $sformatf("row %0d aluSrcE", i));
            checkMem(gotM, expM, $sformatf("row %0d memory levels", i));
        end

        $display("test passed");
        $finish;
    end

endmodule

// File: ctrlPkg.sv
// Control path definitions
// Opcode and function field types, ALU operation, branch condition and
// immediate source encodings, plus the payloads carried by the
// execute and memory stage registers.

package ctrlPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [2:0] funcT;
    typedef logic [1:0] regSrcT;         // register read source select

    // opcode classes, ? bits pick the sub-operation
    localparam opcodeT opAluReg = 6'b000000;
    localparam opcodeT opAluVec = 6'b100000;
    localparam opcodeT opAluImm = 6'b0010??;
    localparam opcodeT opMemS   = 6'b0110??;
    localparam opcodeT opMemV   = 6'b1110??;
    localparam opcodeT opBrCond = 6'b0011??;
    localparam opcodeT opBrJump = 6'b0001??;

    localparam logic [1:0] subOpA = 2'b00;   // str, strv, beq, b
    localparam logic [1:0] subOpB = 2'b01;   // ldr, ldrv, bgt

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSll, aluSrl
    } aluCtrlT;

    typedef enum logic [1:0] {
        condNone,                        // not a branch
        condAlways,
        condEq,                          // taken on zero
        condGt                           // taken on not zero and not negative
    } condT;

    typedef enum logic [1:0] {
        immI     = 2'b00,
        immB     = 2'b01,
        immShamt = 2'b11
    } immSrcT;

    typedef struct packed {
        logic regW;                      // scalar register write
        logic regWV;                     // vector register write
        logic memtoReg;
        logic memW;
        logic memSrc;                    // 1 selects vector memory
        logic memData;
        logic memDataV;
        logic vecData;
    } memCtrlT;

    typedef struct packed {
        aluCtrlT aluCtrl;
        logic    aluSrc;
        condT    cond;
        memCtrlT mem;                    // passed on to the memory stage
    } exCtrlT;

endpackage

// File: ctrlStageReg.sv
// Pipeline control register
// Carries a control payload from one stage to the next. Clear writes a
// bubble and wins over load, hold keeps the current contents.

`timescale 1ns/10ps

module ctrlStageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    hold,
    input  logic    clear,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (clear) begin
            q <= '0;                     // bubble
        end else if (!hold) begin
            q <= d;
        end
    end

    // undriven decode levels would otherwise spread down the pipe
    qKnown: assert property (@(posedge clk) disable iff (!arstN) !$isunknown(q))
        else $error("stage register holds unknown control bits");

endmodule

// File: flist.f
ctrlPkg.sv
mainDecoder.sv
aluDecoder.sv
branchResolve.sv
ctrlStageReg.sv
controlUnit.sv
controlUnitTb.sv

// File: mainDecoder.sv
// Main decoder
// Turns the opcode and function field of the decode-stage instruction
// into the control levels for execute, memory and writeback.
// Opcodes outside the implemented set raise illegalOp and leave
// every enable low.

`timescale 1ns/10ps

module mainDecoder (
    input  ctrlPkg::opcodeT opcode,
    input  ctrlPkg::funcT   func,
    output logic            regW,
    output logic            regWV,
    output logic            memtoReg,
    output logic            memW,
    output logic            memSrc,
    output logic            memData,
    output logic            memDataV,
    output logic            vecData,
    output logic            aluOp,
    output logic            aluSrc,
    output logic            illegalOp,
    output ctrlPkg::condT   cond,
    output ctrlPkg::regSrcT regSrc,
    output ctrlPkg::immSrcT immSrc
);
    import ctrlPkg::*;

    always_comb begin
        regW      = 1'b0;
        regWV     = 1'b0;
        memtoReg  = 1'b0;
        memW      = 1'b0;
        memSrc    = 1'b0;
        memData   = 1'b0;
        memDataV  = 1'b0;
        vecData   = 1'b0;
        aluOp     = 1'b0;                // address add unless overridden
        aluSrc    = 1'b0;
        illegalOp = 1'b0;
        cond      = condNone;
        regSrc    = 2'b00;
        immSrc    = immI;

        casez (opcode)
            opAluReg: begin
                regW  = 1'b1;
                aluOp = 1'b1;
                if (func[1:0] == 2'b11) begin   // sll and srl use shamt
                    aluSrc = 1'b1;
                    immSrc = immShamt;
                end
            end
            opAluVec: begin
                regWV = 1'b1;
                aluOp = 1'b1;
            end
            opAluImm: begin
                regW   = 1'b1;
                aluOp  = 1'b1;
                aluSrc = 1'b1;
            end
            opMemS: begin
                case (opcode[1:0])
                    subOpA: begin        // str
                        memW   = 1'b1;
                        aluSrc = 1'b1;
                        regSrc = 2'b01;  // read the store data register
                    end
                    subOpB: begin        // ldr
                        regW     = 1'b1;
                        memtoReg = 1'b1;
                        aluSrc   = 1'b1;
                    end
                    default: illegalOp = 1'b1;
                endcase
            end
            opMemV: begin
                case (opcode[1:0])
                    subOpA: begin        // strv
                        memW   = 1'b1;
                        memSrc = 1'b1;
                        aluSrc = 1'b1;
                        regSrc = 2'b01;
                    end
                    subOpB: begin        // ldrv
                        regWV    = 1'b1;
                        memtoReg = 1'b1;
                        memSrc   = 1'b1;
                        vecData  = 1'b1;
                        aluSrc   = 1'b1;
                    end
                    default: illegalOp = 1'b1;
                endcase
            end
            opBrCond: begin
                case (opcode[1:0])
                    subOpA: begin        // beq
                        aluOp  = 1'b1;
                        regSrc = 2'b01;
                        cond   = condEq;
                    end
                    subOpB: begin        // bgt
                        aluOp  = 1'b1;
                        regSrc = 2'b01;
                        cond   = condGt;
                    end
                    default: illegalOp = 1'b1;
                endcase
            end
            opBrJump: begin
                if (opcode[1:0] == subOpA) begin   // b
                    cond   = condAlways;
                    immSrc = immB;
                end else begin
                    illegalOp = 1'b1;
                end
            end
            default: illegalOp = 1'b1;
        endcase
    end

    // a result goes to exactly one register file
    regWExcl: assert final (!(regW && regWV))
        else $error("scalar and vector register write both set");

endmodule
